//--- logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and register width
`define CPU_DATA_W 8

// Memory address width
`define CPU_ADDR_W 16

// First opcode fetch address
`define CPU_RESET_PC 16'h0000

`endif

//--- logic/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // Same order as the 3-bit register fields of the opcode
    typedef enum logic [2:0] {
        REG_B = 3'd0,
        REG_C = 3'd1,
        REG_D = 3'd2,
        REG_E = 3'd3,
        REG_H = 3'd4,
        REG_L = 3'd5,
        REG_M = 3'd6,
        REG_A = 3'd7
    } reg_sel_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP,
        ALU_PASS
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    typedef enum logic [2:0] {
        ST_FETCH_OP,
        ST_FETCH_LO,
        ST_FETCH_HI,
        ST_EXECUTE,
        ST_MEM_READ,
        ST_MEM_WRITE,
        ST_HALTED
    } dec_state_t;

    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_HL,
        ADDR_NONE
    } addr_src_t;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   step;
        logic                   jump;
        logic                   relative;
        logic [`CPU_DATA_W-1:0] offset;
    } pc_cmd_t;

endpackage

//--- logic/program_counter.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module program_counter import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  pc_cmd_t                cmd_i,
    input  logic [`CPU_ADDR_W-1:0] target_i,
    output logic [`CPU_ADDR_W-1:0] pc_o
);
    logic [`CPU_ADDR_W-1:0] pc_q;
    logic [`CPU_ADDR_W-1:0] pc_stepped;
    logic [`CPU_ADDR_W-1:0] offset_ext;

    assign pc_stepped = cmd_i.step ? pc_q + 1'b1 : pc_q;

    // Signed displacement of a relative jump
    assign offset_ext = {{(`CPU_ADDR_W - `CPU_DATA_W){cmd_i.offset[`CPU_DATA_W-1]}},
                         cmd_i.offset};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `CPU_RESET_PC;
        end else if (cmd_i.jump) begin
            if (cmd_i.relative) begin
                pc_q <= pc_stepped + offset_ext;
            end else begin
                pc_q <= target_i;
            end
        end else begin
            pc_q <= pc_stepped;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // Read and write selects
    input  reg_sel_t               rd_sel_a_i,
    input  reg_sel_t               rd_sel_b_i,
    input  reg_sel_t               wr_sel_i,
    // Write port
    input  logic                   we_i,
    input  logic [`CPU_DATA_W-1:0] wdata_i,
    input  logic                   flag_we_i,
    input  flags_t                 flags_i,
    // Read ports
    output logic [`CPU_DATA_W-1:0] rdata_a_o,
    output logic [`CPU_DATA_W-1:0] rdata_b_o,
    output logic [`CPU_ADDR_W-1:0] hl_o,
    output flags_t                 flags_o
);
    // Slot M keeps the byte fetched by the last memory read
    logic [`CPU_DATA_W-1:0] regs_q [8];
    flags_t                 f_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            f_q <= '0;
        end else begin
            if (we_i) begin
                regs_q[wr_sel_i] <= wdata_i;
            end
            if (flag_we_i) begin
                f_q <= flags_i;
            end
        end
    end

    assign rdata_a_o = regs_q[rd_sel_a_i];
    assign rdata_b_o = regs_q[rd_sel_b_i];

    // Pointer for the (HL) accesses
    assign hl_o = {regs_q[REG_H], regs_q[REG_L]};

    assign flags_o = f_q;

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t                op_i,
    input  logic [`CPU_DATA_W-1:0] a_i,
    input  logic [`CPU_DATA_W-1:0] b_i,
    input  flags_t                 flags_i,
    output logic [`CPU_DATA_W-1:0] result_o,
    output flags_t                 flags_o
);
    logic [`CPU_DATA_W:0]   wide;
    logic [`CPU_DATA_W-1:0] res;

    always_comb begin
        wide    = '0;
        res     = b_i;
        flags_o = flags_i;
        case (op_i)
            ALU_ADD: begin
                wide      = {1'b0, a_i} + {1'b0, b_i};
                res       = wide[`CPU_DATA_W-1:0];
                flags_o.c = wide[`CPU_DATA_W];
                flags_o.n = 1'b0;
            end
            ALU_SUB, ALU_CP: begin
                // Top bit of the 9-bit difference is the borrow
                wide      = {1'b0, a_i} - {1'b0, b_i};
                res       = wide[`CPU_DATA_W-1:0];
                flags_o.c = wide[`CPU_DATA_W];
                flags_o.n = 1'b1;
            end
            ALU_AND, ALU_XOR, ALU_OR: begin
                if (op_i == ALU_AND) begin
                    res = a_i & b_i;
                end else if (op_i == ALU_XOR) begin
                    res = a_i ^ b_i;
                end else begin
                    res = a_i | b_i;
                end
                flags_o.c = 1'b0;
                flags_o.n = 1'b0;
            end
            default: begin
                res = b_i;
            end
        endcase
        if (op_i != ALU_PASS) begin
            flags_o.z = (res == '0);
            flags_o.h = 1'b0;
        end
    end

    assign result_o = res;

endmodule

//--- logic/instruction_decoder.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instruction_decoder import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`CPU_DATA_W-1:0] mem_rdata_i,
    input  logic                   mem_ack_i,
    input  flags_t                 flags_i,
    output dec_state_t             state_o,
    output addr_src_t              addr_src_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output pc_cmd_t                pc_cmd_o,
    output reg_sel_t               rd_sel_a_o,
    output reg_sel_t               rd_sel_b_o,
    output reg_sel_t               wr_sel_o,
    output logic                   reg_we_o,
    output logic                   flag_we_o,
    output logic                   b_is_imm_o,
    output logic [`CPU_DATA_W-1:0] imm_o,
    output logic [`CPU_ADDR_W-1:0] imm_addr_o,
    output alu_op_t                alu_op_o,
    output logic                   halted_o
);
    dec_state_t             state_q, state_d;
    logic                   read_q, write_q;
    logic                   acked;
    logic [`CPU_DATA_W-1:0] ir_q;
    logic [`CPU_DATA_W-1:0] imm_lo_q, imm_hi_q;
    reg_sel_t               dst_sel, src_sel;
    alu_op_t                alu_sel;
    logic                   alu_valid;
    logic                   is_ld_imm;

    // Operand bytes that follow the opcode
    function automatic logic [1:0] imm_bytes(input logic [`CPU_DATA_W-1:0] op);
        logic [1:0] n;
        n = 2'd0;
        case (op)
            8'h18, 8'h20, 8'h28: n = 2'd1;
            8'hC3:               n = 2'd2;
            default: begin
                if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'b110) begin
                    n = 2'd1;
                end
            end
        endcase
        return n;
    endfunction

    assign acked     = mem_ack_i && (read_q || write_q);
    assign dst_sel   = reg_sel_t'(ir_q[5:3]);
    assign src_sel   = reg_sel_t'(ir_q[2:0]);
    assign is_ld_imm = (ir_q[7:6] == 2'b00) && (src_sel == REG_M) && (dst_sel != REG_M);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FETCH_OP: begin
                if (acked) begin
                    if (imm_bytes(mem_rdata_i) != 2'd0) begin
                        state_d = ST_FETCH_LO;
                    end else if (mem_rdata_i == 8'h7E) begin
                        state_d = ST_MEM_READ;
                    end else begin
                        state_d = ST_EXECUTE;
                    end
                end
            end
            ST_FETCH_LO: begin
                if (acked) begin
                    state_d = (imm_bytes(ir_q) == 2'd2) ? ST_FETCH_HI : ST_EXECUTE;
                end
            end
            ST_FETCH_HI, ST_MEM_READ: begin
                if (acked) begin
                    state_d = ST_EXECUTE;
                end
            end
            ST_EXECUTE: begin
                if (ir_q == 8'h76) begin
                    state_d = ST_HALTED;
                end else if (ir_q == 8'h77) begin
                    state_d = ST_MEM_WRITE;
                end else begin
                    state_d = ST_FETCH_OP;
                end
            end
            ST_MEM_WRITE: begin
                if (acked) begin
                    state_d = ST_FETCH_OP;
                end
            end
            ST_HALTED: state_d = ST_HALTED;
            default:   state_d = ST_FETCH_OP;
        endcase
    end

    // Request lines follow the next state so they start with it
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_FETCH_OP;
            read_q  <= 1'b0;
            write_q <= 1'b0;
            ir_q    <= '0;
        end else begin
            state_q <= state_d;
            read_q  <= (state_d == ST_FETCH_OP) || (state_d == ST_FETCH_LO) ||
                       (state_d == ST_FETCH_HI) || (state_d == ST_MEM_READ);
            write_q <= (state_d == ST_MEM_WRITE);
            if (acked && state_q == ST_FETCH_OP) begin
                ir_q <= mem_rdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acked && state_q == ST_FETCH_LO) begin
            imm_lo_q <= mem_rdata_i;
        end
        if (acked && state_q == ST_FETCH_HI) begin
            imm_hi_q <= mem_rdata_i;
        end
    end

    // Operation field of the 80 to BF block
    always_comb begin
        alu_valid = 1'b1;
        case (ir_q[5:3])
            3'b000: alu_sel = ALU_ADD;
            3'b010: alu_sel = ALU_SUB;
            3'b100: alu_sel = ALU_AND;
            3'b101: alu_sel = ALU_XOR;
            3'b110: alu_sel = ALU_OR;
            3'b111: alu_sel = ALU_CP;
            default: begin
                alu_sel   = ALU_PASS;
                alu_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        addr_src_o      = ADDR_NONE;
        pc_cmd_o        = '0;
        pc_cmd_o.offset = imm_lo_q;
        rd_sel_a_o      = REG_A;
        rd_sel_b_o      = src_sel;
        wr_sel_o        = dst_sel;
        reg_we_o        = 1'b0;
        flag_we_o       = 1'b0;
        b_is_imm_o      = 1'b0;
        alu_op_o        = ALU_PASS;
        case (state_q)
            ST_FETCH_OP, ST_FETCH_LO, ST_FETCH_HI: begin
                addr_src_o    = ADDR_PC;
                pc_cmd_o.step = acked;
            end
            ST_MEM_READ: begin
                addr_src_o = ADDR_HL;
                wr_sel_o   = REG_M;
                reg_we_o   = acked;
            end
            ST_MEM_WRITE: begin
                addr_src_o = ADDR_HL;
            end
            ST_EXECUTE: begin
                case (ir_q[7:6])
                    2'b00: begin
                        b_is_imm_o = is_ld_imm;
                        reg_we_o   = is_ld_imm;
                    end
                    2'b01: begin
                        reg_we_o = (dst_sel != REG_M) && (src_sel != REG_M || ir_q == 8'h7E);
                    end
                    2'b10: begin
                        if (src_sel != REG_M && alu_valid) begin
                            alu_op_o  = alu_sel;
                            wr_sel_o  = REG_A;
                            flag_we_o = 1'b1;
                            reg_we_o  = (alu_sel != ALU_CP);
                        end
                    end
                    default: ;
                endcase
                // A failed JR keeps the PC already stepped past its offset
                pc_cmd_o.relative = (ir_q != 8'hC3);
                case (ir_q)
                    8'hC3:   pc_cmd_o.jump = 1'b1;
                    8'h18:   pc_cmd_o.jump = 1'b1;
                    8'h20:   pc_cmd_o.jump = !flags_i.z;
                    8'h28:   pc_cmd_o.jump = flags_i.z;
                    default: pc_cmd_o.jump = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign state_o     = state_q;
    assign mem_read_o  = read_q;
    assign mem_write_o = write_q;
    assign imm_o       = imm_lo_q;
    assign imm_addr_o  = {imm_hi_q, imm_lo_q};
    assign halted_o    = (state_q == ST_HALTED);

endmodule

//--- logic/control_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module control_unit import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // Memory side
    input  logic [`CPU_DATA_W-1:0] mem_rdata_i,
    input  logic                   mem_ack_i,
    // ALU side
    input  logic [`CPU_DATA_W-1:0] alu_result_i,
    input  flags_t                 alu_flags_i,
    output alu_op_t                alu_op_o,
    output logic [`CPU_DATA_W-1:0] op_a_o,
    output logic [`CPU_DATA_W-1:0] op_b_o,
    output flags_t                 flags_o,
    output mem_req_t               mem_req_o,
    output logic                   halted_o
);
    dec_state_t             id_state;
    addr_src_t              id_addr_src;
    logic                   id_mem_read, id_mem_write;
    pc_cmd_t                id_pc_cmd;
    reg_sel_t               id_rd_sel_a, id_rd_sel_b, id_wr_sel;
    logic                   id_reg_we, id_flag_we, id_b_is_imm;
    logic [`CPU_DATA_W-1:0] id_imm;
    logic [`CPU_ADDR_W-1:0] id_imm_addr;
    logic [`CPU_DATA_W-1:0] rf_rdata_a, rf_rdata_b, rf_wdata;
    logic [`CPU_ADDR_W-1:0] rf_hl, pc;

    // Operand mux
    assign op_a_o = rf_rdata_a;
    assign op_b_o = id_b_is_imm ? id_imm : rf_rdata_b;

    // Loaded bytes bypass the ALU on their way into slot M
    assign rf_wdata = (id_state == ST_MEM_READ) ? mem_rdata_i : alu_result_i;

    always_comb begin
        mem_req_o.read  = id_mem_read;
        mem_req_o.write = id_mem_write;
        mem_req_o.wdata = rf_rdata_a;
        case (id_addr_src)
            ADDR_PC: mem_req_o.addr = pc;
            ADDR_HL: mem_req_o.addr = rf_hl;
            default: mem_req_o.addr = '0;
        endcase
    end

    instruction_decoder u_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i),
        .flags_i     (flags_o),
        .state_o     (id_state),
        .addr_src_o  (id_addr_src),
        .mem_read_o  (id_mem_read),
        .mem_write_o (id_mem_write),
        .pc_cmd_o    (id_pc_cmd),
        .rd_sel_a_o  (id_rd_sel_a),
        .rd_sel_b_o  (id_rd_sel_b),
        .wr_sel_o    (id_wr_sel),
        .reg_we_o    (id_reg_we),
        .flag_we_o   (id_flag_we),
        .b_is_imm_o  (id_b_is_imm),
        .imm_o       (id_imm),
        .imm_addr_o  (id_imm_addr),
        .alu_op_o    (alu_op_o),
        .halted_o    (halted_o)
    );

    register_file u_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_sel_a_i (id_rd_sel_a),
        .rd_sel_b_i (id_rd_sel_b),
        .wr_sel_i   (id_wr_sel),
        .we_i       (id_reg_we),
        .wdata_i    (rf_wdata),
        .flag_we_i  (id_flag_we),
        .flags_i    (alu_flags_i),
        .rdata_a_o  (rf_rdata_a),
        .rdata_b_o  (rf_rdata_b),
        .hl_o       (rf_hl),
        .flags_o    (flags_o)
    );

    program_counter u_pc (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .cmd_i    (id_pc_cmd),
        .target_i (id_imm_addr),
        .pc_o     (pc)
    );

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    output mem_req_t               mem_req_o,
    input  logic [`CPU_DATA_W-1:0] mem_rdata_i,
    input  logic                   mem_ack_i,
    output logic                   halted_o
);
    alu_op_t                alu_op;
    logic [`CPU_DATA_W-1:0] op_a, op_b, alu_result;
    flags_t                 flags, alu_flags;

    control_unit u_cu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ack_i    (mem_ack_i),
        .alu_result_i (alu_result),
        .alu_flags_i  (alu_flags),
        .alu_op_o     (alu_op),
        .op_a_o       (op_a),
        .op_b_o       (op_b),
        .flags_o      (flags),
        .mem_req_o    (mem_req_o),
        .halted_o     (halted_o)
    );

    alu u_alu (
        .op_i     (alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .flags_i  (flags),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

endmodule

//--- verification/cpu_core_sva.sv
`timescale 1ns/1ps

module cpu_core_sva import cpu_pkg::*; (
    input logic     clk,
    input logic     rst_n_i,
    input mem_req_t mem_req_o,
    input logic     mem_ack_i,
    input logic     halted_o
);
    logic req;

    assign req = mem_req_o.read || mem_req_o.write;

    // Read and write are exclusive
    rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_req_o.read && mem_req_o.write))
        else $error("memory read and write raised together");

    // Pending request keeps address and write data until acknowledged
    req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req && !mem_ack_i) |=> $stable(mem_req_o))
        else $error("memory request changed before its acknowledge");

    no_req_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_o |-> !req)
        else $error("memory request issued while halted");

endmodule

bind cpu_core cpu_core_sva u_sva (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .mem_req_o (mem_req_o),
    .mem_ack_i (mem_ack_i),
    .halted_o  (halted_o)
);

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core_tb import cpu_pkg::*; ();
    localparam logic [2:0] OP_ADD = 3'd0;
    localparam logic [2:0] OP_SUB = 3'd2;
    localparam logic [2:0] OP_AND = 3'd4;
    localparam logic [2:0] OP_XOR = 3'd5;
    localparam logic [2:0] OP_OR  = 3'd6;
    localparam logic [2:0] OP_CP  = 3'd7;

    logic                   clk;
    logic                   rst_n_i;
    mem_req_t               mem_req_o;
    logic [`CPU_DATA_W-1:0] mem_rdata_i;
    logic                   mem_ack_i;
    logic                   halted_o;

    logic [7:0]  mem     [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] asm_ptr;
    logic [31:0] rng_state;
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [15:0] obs_addr [$];
    logic [7:0]  obs_data [$];
    int          obs_fetches;
    int          test_errs;
    int          n_pass;
    int          n_fail;
    int          ack_delay;
    logic        pending;
    logic        running;
    time         deadline;
    string       cur_test;

    cpu_core UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i),
        .halted_o    (halted_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Instruction-level model of the subset that runs until HALT
    function automatic int run_model(output int accesses, output bit halted);
        logic [7:0]  r [8];
        logic [15:0] pc;
        logic [15:0] hl;
        logic [7:0]  op;
        logic [7:0]  e;
        logic [8:0]  wide;
        logic        z;
        int          fetches;
        for (int i = 0; i < 8; i++) begin
            r[i] = 8'h00;
        end
        pc = `CPU_RESET_PC;
        z = 1'b0;
        fetches = 0;
        accesses = 0;
        halted = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        while (!halted && fetches < 4096) begin
            op = ref_mem[pc];
            hl = {r[4], r[5]};
            e = ref_mem[pc + 16'd1];
            fetches++;
            accesses++;
            if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'b110) begin
                r[op[5:3]] = e;
                accesses++;
                pc = pc + 16'd2;
            end else if (op == 8'h18 || (op == 8'h20 && !z) || (op == 8'h28 && z)) begin
                accesses++;
                pc = pc + 16'd2 + {{8{e[7]}}, e};
            end else if (op == 8'h20 || op == 8'h28) begin
                accesses++;
                pc = pc + 16'd2;
            end else if (op == 8'hC3) begin
                accesses += 2;
                pc = {ref_mem[pc + 16'd2], e};
            end else if (op == 8'h76) begin
                halted = 1'b1;
            end else if (op == 8'h77) begin
                exp_addr.push_back(hl);
                exp_data.push_back(r[7]);
                ref_mem[hl] = r[7];
                accesses++;
                pc = pc + 16'd1;
            end else if (op == 8'h7E) begin
                r[7] = ref_mem[hl];
                accesses++;
                pc = pc + 16'd1;
            end else if (op[7:6] == 2'b01) begin
                if (op[5:3] != 3'b110 && op[2:0] != 3'b110) begin
                    r[op[5:3]] = r[op[2:0]];
                end
                pc = pc + 16'd1;
            end else if (op[7:6] == 2'b10 && op[2:0] != 3'b110 &&
                         op[5:3] != 3'b001 && op[5:3] != 3'b011) begin
                case (op[5:3])
                    OP_ADD:  wide = {1'b0, r[7]} + {1'b0, r[op[2:0]]};
                    OP_AND:  wide = {1'b0, r[7] & r[op[2:0]]};
                    OP_XOR:  wide = {1'b0, r[7] ^ r[op[2:0]]};
                    OP_OR:   wide = {1'b0, r[7] | r[op[2:0]]};
                    default: wide = {1'b0, r[7]} - {1'b0, r[op[2:0]]};
                endcase
                z = (wide[7:0] == 8'h00);
                // CP keeps A
                if (op[5:3] != OP_CP) begin
                    r[7] = wide[7:0];
                end
                pc = pc + 16'd1;
            end else begin
                pc = pc + 16'd1;
            end
        end
        return fetches;
    endfunction

    task automatic clear_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        asm_ptr = `CPU_RESET_PC;
    endtask

    task automatic put_byte(input logic [7:0] b);
        mem[asm_ptr] = b;
        asm_ptr = asm_ptr + 16'd1;
    endtask

    task automatic ld_imm(input reg_sel_t r, input logic [7:0] v);
        put_byte({2'b00, r, 3'b110});
        put_byte(v);
    endtask

    task automatic ld_reg(input reg_sel_t d, input reg_sel_t s);
        put_byte({2'b01, d, s});
    endtask

    task automatic alu_reg(input logic [2:0] op, input reg_sel_t s);
        put_byte({2'b10, op, s});
    endtask

    task automatic jr_to(input logic [7:0] opc, input logic [15:0] target);
        logic [15:0] diff;
        diff = target - (asm_ptr + 16'd2);
        put_byte(opc);
        put_byte(diff[7:0]);
    endtask

    // Result to (HL) and a marker chosen by JR Z to the next slot
    task automatic flag_probe(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
                              input logic [7:0] slot);
        ld_imm(REG_A, a);
        ld_imm(REG_B, b);
        alu_reg(op, REG_B);
        ld_imm(REG_L, slot);
        put_byte(8'h77);
        ld_imm(REG_L, slot + 8'd1);
        put_byte(8'h28);
        put_byte(8'd4);
        ld_imm(REG_A, 8'h11);
        put_byte(8'h18);
        put_byte(8'd2);
        ld_imm(REG_A, 8'h22);
        put_byte(8'h77);
    endtask

    task automatic loads_program();
        reg_sel_t srcs [4];
        srcs = '{REG_B, REG_C, REG_D, REG_E};
        clear_memory();
        ld_imm(REG_H, 8'h90);
        ld_imm(REG_L, 8'h00);
        for (int i = 0; i < 4; i++) begin
            ld_imm(srcs[i], 8'(rand_next()));
        end
        ld_imm(REG_A, 8'(rand_next()));
        put_byte(8'h77);
        for (int i = 0; i < 4; i++) begin
            ld_imm(REG_L, 8'(i + 1));
            ld_reg(REG_A, srcs[i]);
            put_byte(8'h77);
        end
        // Register to register chain
        ld_imm(REG_B, 8'(rand_next()));
        ld_reg(REG_C, REG_B);
        ld_reg(REG_D, REG_C);
        ld_reg(REG_E, REG_D);
        ld_reg(REG_A, REG_E);
        ld_imm(REG_L, 8'h10);
        put_byte(8'h77);
        ld_reg(REG_A, REG_H);
        ld_imm(REG_L, 8'h20);
        put_byte(8'h77);
        ld_imm(REG_H, 8'h7F);
        ld_imm(REG_L, 8'h80);
        ld_reg(REG_A, REG_L);
        put_byte(8'h77);
        put_byte(8'h76);
    endtask

    task automatic arith_program();
        logic [7:0] a;
        logic [7:0] b;
        logic [2:0] op;
        clear_memory();
        ld_imm(REG_H, 8'hA0);
        for (int i = 0; i < 8; i++) begin
            op = i[0] ? OP_SUB : OP_ADD;
            a = 8'(rand_next());
            b = 8'(rand_next());
            // Second half forces a zero result
            if (i >= 4) begin
                b = (op == OP_ADD) ? 8'h00 - a : a;
            end
            flag_probe(op, a, b, 8'(2 * i));
        end
        put_byte(8'h76);
    endtask

    task automatic logic_program();
        logic [7:0] a;
        clear_memory();
        ld_imm(REG_H, 8'hA0);
        a = 8'(rand_next());
        flag_probe(OP_AND, a, 8'(rand_next()), 8'h00);
        flag_probe(OP_AND, a, ~a, 8'h02);
        flag_probe(OP_XOR, a, 8'(rand_next()), 8'h04);
        flag_probe(OP_XOR, a, a, 8'h06);
        flag_probe(OP_OR, a, 8'(rand_next()), 8'h08);
        flag_probe(OP_OR, 8'h00, 8'h00, 8'h0A);
        flag_probe(OP_CP, a, a + 8'd1, 8'h0C);
        flag_probe(OP_CP, a, a, 8'h0E);
        put_byte(8'h76);
    endtask

    task automatic branch_program();
        logic [15:0] loop_top;
        logic [15:0] back;
        clear_memory();
        put_byte(8'hC3);
        put_byte(8'h00);
        put_byte(8'h01);
        // Reached only if JP fails
        ld_imm(REG_A, 8'hEE);
        put_byte(8'h77);
        put_byte(8'h76);
        asm_ptr = 16'h0100;
        ld_imm(REG_H, 8'hB0);
        ld_imm(REG_L, 8'h00);
        ld_imm(REG_B, 8'd5);
        ld_imm(REG_C, 8'd1);
        loop_top = asm_ptr;
        ld_reg(REG_A, REG_B);
        put_byte(8'h77);
        ld_reg(REG_A, REG_L);
        alu_reg(OP_ADD, REG_C);
        ld_reg(REG_L, REG_A);
        ld_reg(REG_A, REG_B);
        alu_reg(OP_SUB, REG_C);
        ld_reg(REG_B, REG_A);
        jr_to(8'h20, loop_top);
        put_byte(8'h18);
        put_byte(8'd3);
        ld_imm(REG_A, 8'hEE);
        put_byte(8'h77);
        put_byte(8'h18);
        put_byte(8'd4);
        back = asm_ptr;
        ld_imm(REG_A, 8'h5A);
        put_byte(8'h77);
        put_byte(8'h76);
        ld_imm(REG_L, 8'h40);
        jr_to(8'h18, back);
    endtask

    task automatic mem_read_program();
        clear_memory();
        for (int i = 0; i < 8; i++) begin
            mem[16'h3000 + i] = 8'(rand_next());
        end
        for (int i = 0; i < 6; i++) begin
            ld_imm(REG_H, 8'h30);
            ld_imm(REG_L, 8'(i));
            put_byte(8'h7E);
            ld_imm(REG_H, 8'h31);
            put_byte(8'h77);
        end
        // Read back two stored bytes and store their sum
        ld_imm(REG_L, 8'h00);
        put_byte(8'h7E);
        ld_reg(REG_B, REG_A);
        ld_imm(REG_L, 8'h01);
        put_byte(8'h7E);
        alu_reg(OP_ADD, REG_B);
        ld_imm(REG_H, 8'h32);
        put_byte(8'h77);
        put_byte(8'h76);
    endtask

    task automatic halt_program();
        clear_memory();
        ld_imm(REG_A, 8'h77);
        ld_imm(REG_H, 8'hC0);
        put_byte(8'h76);
        put_byte(8'h77);
        put_byte(8'h77);
    endtask

    task automatic run_test(input string name);
        int  accesses;
        int  exp_fetches;
        int  n_writes;
        bit  model_done;
        @(posedge clk);
        #1 rst_n_i = 1'b0;
        cur_test = name;
        test_errs = 0;
        ref_mem = mem;
        exp_fetches = run_model(accesses, model_done);
        n_writes = exp_addr.size();
        assert (model_done) else begin
            $display("Reference model never reached HALT in test %s", name);
            test_errs++;
        end
        obs_addr.delete();
        obs_data.delete();
        obs_fetches = 0;
        repeat (10) @(posedge clk);
        #1 rst_n_i = 1'b1;
        deadline = $time + (60 * accesses + 60) * 20;
        running = 1'b1;
        while (!halted_o) begin
            @(negedge clk);
        end
        repeat (50) begin
            @(negedge clk);
            assert (!mem_req_o.read && !mem_req_o.write) else begin
                $display("Memory request issued after HALT at %0t", $time);
                test_errs++;
            end
        end
        running = 1'b0;
        assert (exp_addr.size() == 0) else begin
            $display("%0d expected writes never appeared in test %s", exp_addr.size(), name);
            test_errs++;
        end
        assert (obs_fetches == exp_fetches) else begin
            $display("MISMATCH at %0t: opcode fetches expected %0d, got %0d",
                     $time, exp_fetches, obs_fetches);
            test_errs++;
        end
        if (test_errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("Test %s %s (%0d writes, %0d fetches, %0d errors)", name,
                 (test_errs == 0) ? "passed" : "failed", n_writes, exp_fetches, test_errs);
    endtask

    // Memory with a random acknowledge delay of 0 to 3 cycles
    always @(posedge clk) begin
        #1;
        mem_ack_i = 1'b0;
        if (mem_req_o.read || mem_req_o.write) begin
            if (!pending) begin
                pending   = 1'b1;
                ack_delay = int'(rand_next() & 32'd3);
            end
            if (ack_delay == 0) begin
                pending   = 1'b0;
                mem_ack_i = 1'b1;
                if (mem_req_o.read) begin
                    mem_rdata_i = mem[mem_req_o.addr];
                    if (UUT.u_cu.id_state == ST_FETCH_OP) begin
                        obs_fetches++;
                    end
                end else begin
                    mem[mem_req_o.addr] = mem_req_o.wdata;
                    obs_addr.push_back(mem_req_o.addr);
                    obs_data.push_back(mem_req_o.wdata);
                end
            end else begin
                ack_delay--;
            end
        end else begin
            pending = 1'b0;
        end
    end

    always @(negedge clk) begin : compare_writes
        logic [15:0] a;
        logic [7:0]  d;
        logic [15:0] ea;
        logic [7:0]  ed;
        while (obs_addr.size() != 0) begin
            a = obs_addr.pop_front();
            d = obs_data.pop_front();
            assert (exp_addr.size() != 0) else begin
                $display("Unexpected extra write of %h to %h at %0t", d, a, $time);
                test_errs++;
            end
            if (exp_addr.size() != 0) begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                assert (a == ea) else begin
                    $display("MISMATCH at %0t: mem_req_o.addr expected %h, got %h", $time, ea, a);
                    test_errs++;
                end
                assert (d == ed) else begin
                    $display("MISMATCH at %0t: mem_req_o.wdata expected %h, got %h", $time, ed, d);
                    test_errs++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (running && $time > deadline) begin
            $display("Timeout in test %s: core did not halt within its cycle budget", cur_test);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        rng_state = 32'h825e_75a4;
        pending = 1'b0;
        ack_delay = 0;
        running = 1'b0;
        deadline = 0;
        n_pass = 0;
        n_fail = 0;
        loads_program();
        run_test("loads_stores");
        arith_program();
        run_test("arith_flags");
        logic_program();
        run_test("logic_compare");
        branch_program();
        run_test("control_flow");
        mem_read_program();
        run_test("memory_reads");
        halt_program();
        run_test("halt");
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/cpu_pkg.sv
logic/program_counter.sv
logic/register_file.sv
logic/alu.sv
logic/instruction_decoder.sv
logic/control_unit.sv
logic/cpu_core.sv
verification/cpu_core_sva.sv
verification/cpu_core_tb.sv
